// File: verilog/core_pkg.sv
package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // One queue slot
    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
    } fetch_entry_t;

    typedef struct packed {
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        xlen_t    imm;
        logic     use_imm;
        logic     reg_write;
        logic     illegal;
    } decoded_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        reg_idx_t rd;
        xlen_t    value;
        logic     write;
        logic     illegal;
    } retire_t;

endpackage

// File: verilog/bus_pkg.sv
package bus_pkg;

    // Read address channel, core to memory
    typedef struct packed {
        logic [31:0] araddr;
        logic        arvalid;
    } axi_ar_t;

    // Read data channel, memory to core
    typedef struct packed {
        logic [31:0] rdata;
        logic        rvalid;
    } axi_r_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA
    } fetch_state_e;

endpackage

// File: verilog/int_alu.sv
`timescale 1ns/10ps

module int_alu (
    input  core_pkg::alu_op_e op,
    input  core_pkg::xlen_t   a,
    input  core_pkg::xlen_t   b,
    output core_pkg::xlen_t   result
);
    import core_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'd0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            // Sign bit fills from the left
            ALU_SRA:    result = xlen_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// File: verilog/int_regfile.sv
`timescale 1ns/10ps

module int_regfile (
    input  logic               clk,
    input  logic               we,
    input  core_pkg::reg_idx_t waddr,
    input  core_pkg::xlen_t    wdata,
    input  core_pkg::reg_idx_t raddr1,
    input  core_pkg::reg_idx_t raddr2,
    output core_pkg::xlen_t    rdata1,
    output core_pkg::xlen_t    rdata2
);
    import core_pkg::*;

    // x0 has no storage
    xlen_t regs [31:1];

    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// File: verilog/inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
    input  core_pkg::xlen_t    inst,
    output core_pkg::decoded_t dec
);
    import core_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;
    xlen_t      imm_i;
    xlen_t      imm_u;

    // alt is funct7 bit 5; SUB only exists for register-register ops
    function automatic alu_op_e map_alu(input logic [2:0] f3, input logic f7_5,
                                        input logic allow_sub);
        alu_op_e op;
        case (f3)
            3'd0: op = (f7_5 && allow_sub) ? ALU_SUB : ALU_ADD;
            3'd1: op = ALU_SLL;
            3'd2: op = ALU_SLT;
            3'd3: op = ALU_SLTU;
            3'd4: op = ALU_XOR;
            3'd5: op = f7_5 ? ALU_SRA : ALU_SRL;
            3'd6: op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_u  = {inst[31:12], 12'h000};

    always_comb begin
        dec.alu_op    = ALU_ADD;
        dec.rd        = inst[11:7];
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.imm       = imm_i;
        dec.use_imm   = 1'b0;
        dec.reg_write = 1'b0;
        dec.illegal   = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec.alu_op    = map_alu(funct3, alt, 1'b1);
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.alu_op    = map_alu(funct3, alt, 1'b0);
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op    = ALU_PASS_B;
                dec.imm       = imm_u;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
            end
            default: begin
                dec.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: verilog/inst_fetch.sv
`timescale 1ns/10ps

module inst_fetch #(
    parameter core_pkg::xlen_t RESET_PC = 32'h0000_1000
) (
    input  logic                   clk,
    input  logic                   reset,
    output bus_pkg::axi_ar_t       ar,
    input  logic                   arready,
    input  bus_pkg::axi_r_t        r,
    output logic                   rready,
    input  logic                   full,
    output logic                   push,
    output core_pkg::fetch_entry_t entry
);
    import core_pkg::*;
    import bus_pkg::*;

    fetch_state_e state;
    xlen_t        pc;

    // One read in flight at a time, address held for the whole request
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH_IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (!full) begin
                        state <= FETCH_ADDR;
                    end
                end
                FETCH_ADDR: begin
                    if (arready) begin
                        state <= FETCH_DATA;
                    end
                end
                FETCH_DATA: begin
                    if (r.rvalid) begin
                        state <= FETCH_IDLE;
                        pc    <= pc + 32'd4;
                    end
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    assign ar.araddr  = pc;
    assign ar.arvalid = (state == FETCH_ADDR);
    assign rready     = (state == FETCH_DATA);

    // Data beat goes straight into the queue
    assign push       = rready && r.rvalid;
    assign entry.pc   = pc;
    assign entry.inst = r.rdata;

endmodule

// File: verilog/inst_queue.sv
`timescale 1ns/10ps

module inst_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  core_pkg::fetch_entry_t entry,
    output logic                   full,
    output logic                   valid,
    output core_pkg::fetch_entry_t head,
    input  logic                   pop
);
    import core_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_entry_t     mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign do_pop = pop && valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= entry;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign full  = (count == CNT_W'(QUEUE_DEPTH));
    assign valid = (count != '0);
    assign head  = mem[rd_ptr];

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   valid,
    input  core_pkg::fetch_entry_t head,
    output logic                   pop,
    output core_pkg::retire_t      retire
);
    import core_pkg::*;

    decoded_t dec;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    xlen_t    op_b;
    xlen_t    alu_out;
    logic     wr_en;

    inst_decode u_decode (
        .inst (head.inst),
        .dec  (dec)
    );

    // Write lands on the popping edge, so the next instruction sees it
    int_regfile u_regfile (
        .clk    (clk),
        .we     (wr_en),
        .waddr  (dec.rd),
        .wdata  (alu_out),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val)
    );

    int_alu u_alu (
        .op     (dec.alu_op),
        .a      (rs1_val),
        .b      (op_b),
        .result (alu_out)
    );

    assign pop   = valid;
    assign op_b  = dec.use_imm ? dec.imm : rs2_val;
    assign wr_en = valid && dec.reg_write;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= valid;
        end
        if (valid) begin
            retire.pc      <= head.pc;
            retire.rd      <= dec.rd;
            retire.value   <= dec.illegal ? '0 : alu_out;
            retire.write   <= dec.reg_write;
            retire.illegal <= dec.illegal;
        end
    end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
    parameter core_pkg::xlen_t RESET_PC    = 32'h0000_1000,
    parameter int              QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset,
    output bus_pkg::axi_ar_t  ar,
    input  logic              arready,
    input  bus_pkg::axi_r_t   r,
    output logic              rready,
    output core_pkg::retire_t retire
);
    import core_pkg::*;

    logic         q_full;
    logic         q_push;
    logic         q_valid;
    logic         q_pop;
    fetch_entry_t q_in;
    fetch_entry_t q_head;

    inst_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk     (clk),
        .reset   (reset),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .full    (q_full),
        .push    (q_push),
        .entry   (q_in)
    );

    inst_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk   (clk),
        .reset (reset),
        .push  (q_push),
        .entry (q_in),
        .full  (q_full),
        .valid (q_valid),
        .head  (q_head),
        .pop   (q_pop)
    );

    exec_stage u_exec (
        .clk    (clk),
        .reset  (reset),
        .valid  (q_valid),
        .head   (q_head),
        .pop    (q_pop),
        .retire (retire)
    );

endmodule

// File: verification/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;
    import core_pkg::*;
    import bus_pkg::*;

    localparam xlen_t      RESET_PC    = 32'h0000_1000;
    localparam int         TIMEOUT     = 50;
    localparam int         NUM_RETIRES = 300;
    localparam logic [6:0] RV_OP       = 7'b0110011;
    localparam logic [6:0] RV_OP_IMM   = 7'b0010011;
    localparam logic [6:0] RV_LUI      = 7'b0110111;
    localparam int         T_RESET     = 0;
    localparam int         T_BUS       = 1;
    localparam int         T_REG       = 2;
    localparam int         T_IMM       = 3;
    localparam int         T_ILL       = 4;
    localparam int         T_ORDER     = 5;

    logic        clk;
    logic        reset;
    axi_ar_t     ar;
    logic        arready;
    axi_r_t      r;
    logic        rready;
    retire_t     retire;

    logic [31:0] seed;
    logic [31:0] prog [64];
    logic [31:0] mregs [32];
    xlen_t       exp_pc;
    string       test_name [6];
    int          n_checks [6];
    int          n_errs [6];
    int          n_retired;
    int          cycles;
    int          last_count;
    int          total_checks;
    int          total_errs;
    bit          timed_out;

    // Bus monitor and slave state
    bit          hold_pending;
    xlen_t       held_addr;
    bit          seen_addr;
    xlen_t       last_addr;
    bit          ar_fire;
    xlen_t       fire_addr;
    bit          r_fire;
    bit          have_req;
    xlen_t       req_addr;
    logic [1:0]  ar_wait;
    logic [1:0]  r_wait;
    bit          in_reset;

    // Retire checker state
    logic [31:0] cur_inst;
    logic [31:0] e_val;
    logic        e_wr;
    logic        e_ill;
    int          kind;

    cpu_top #(
        .RESET_PC    (RESET_PC),
        .QUEUE_DEPTH (4)
    ) UUT (
        .clk     (clk),
        .reset   (reset),
        .ar      (ar),
        .arready (arready),
        .r       (r),
        .rready  (rready),
        .retire  (retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input int t, input string what, input logic [31:0] exp,
                             input logic [31:0] act);
        n_checks[t]++;
        assert (exp === act) else begin
            $display("FAILED %s %s: expected %h actual %h", test_name[t], what, exp, act);
            n_errs[t]++;
        end
    endtask

    task automatic expect_true(input int t, input logic ok, input string msg);
        n_checks[t]++;
        assert (ok === 1'b1) else begin
            $display("ERROR %s: %s", test_name[t], msg);
            n_errs[t]++;
        end
    endtask

    // Words 0 to 6 load x1..x7 so the model never depends on unknown registers
    task automatic fill_program();
        int          i;
        logic [31:0] w;
        logic [3:0]  pick;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [6:0]  f7;
        for (i = 0; i < 64; i++) begin
            pick = 4'($random(seed));
            f3   = 3'($random(seed));
            rd   = 5'($random(seed) & 7);
            rs1  = 5'($random(seed) & 7);
            rs2  = 5'($random(seed) & 7);
            imm  = 12'($random(seed));
            if (i < 7) begin
                w = {imm, 5'd0, 3'd0, 5'(i + 1), RV_OP_IMM};
            end else if (pick == 4'd0) begin
                w = $random(seed);
                case (w[8:7])
                    2'd0: w[6:0] = 7'b0000011;
                    2'd1: w[6:0] = 7'b0100011;
                    2'd2: w[6:0] = 7'b1100011;
                    default: w[6:0] = 7'b1101111;
                endcase
            end else if (pick <= 4'd6) begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'b0100000 : 7'b0000000;
                w  = {f7, rs2, rs1, f3, rd, RV_OP};
            end else if (pick <= 4'd12) begin
                if (f3 == 3'd1) begin
                    imm = {7'b0000000, imm[4:0]};
                end else if (f3 == 3'd5) begin
                    imm = {imm[11] ? 7'b0100000 : 7'b0000000, imm[4:0]};
                end
                w = {imm, rs1, f3, rd, RV_OP_IMM};
            end else begin
                w        = $random(seed);
                w[11:0]  = {rd, RV_LUI};
            end
            prog[i] = w;
        end
    endtask

    function automatic void model_result(input logic [31:0] inst, output logic [31:0] val,
                                         output logic wr, output logic ill);
        logic [2:0]         f3;
        logic [31:0]        a;
        logic [31:0]        b;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        logic [4:0]         sh;
        f3 = inst[14:12];
        a  = mregs[inst[19:15]];
        if (inst[6:0] == RV_OP) begin
            b = mregs[inst[24:20]];
        end else begin
            b = {{20{inst[31]}}, inst[31:20]};
        end
        sa  = a;
        sb  = b;
        sh  = b[4:0];
        val = 32'd0;
        wr  = 1'b0;
        ill = 1'b0;
        if (inst[6:0] == RV_LUI) begin
            val = {inst[31:12], 12'd0};
            wr  = 1'b1;
        end else if (inst[6:0] == RV_OP || inst[6:0] == RV_OP_IMM) begin
            wr = 1'b1;
            case (f3)
                3'd0: val = (inst[6:0] == RV_OP && inst[30]) ? a - b : a + b;
                3'd1: val = a << sh;
                3'd2: val = (sa < sb) ? 32'd1 : 32'd0;
                3'd3: val = (a < b) ? 32'd1 : 32'd0;
                3'd4: val = a ^ b;
                3'd5: begin
                    if (inst[30]) begin
                        val = sa >>> sh;
                    end else begin
                        val = a >> sh;
                    end
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end else begin
            ill = 1'b1;
        end
    endfunction

    // Memory drives the read channels just after the edge
    always @(posedge clk) begin
        in_reset = reset;
        #2;
        if (in_reset) begin
            arready  = 1'b0;
            r        = '0;
            have_req = 1'b0;
            ar_wait  = 2'd0;
            r_wait   = 2'd0;
        end else begin
            if (ar_fire) begin
                arready  = 1'b0;
                have_req = 1'b1;
                req_addr = fire_addr;
                ar_wait  = 2'($random(seed));
                r_wait   = 2'($random(seed));
            end
            if (r_fire) begin
                r.rvalid = 1'b0;
                have_req = 1'b0;
            end
            if (!have_req && ar.arvalid && !arready) begin
                if (ar_wait == 2'd0) begin
                    arready = 1'b1;
                end else begin
                    ar_wait = ar_wait - 2'd1;
                end
            end
            if (have_req && !r.rvalid) begin
                if (r_wait == 2'd0) begin
                    r.rvalid = 1'b1;
                    r.rdata  = prog[req_addr[7:2]];
                end else begin
                    r_wait = r_wait - 2'd1;
                end
            end
        end
    end

    // Mid-cycle sampling of the bus and the retire record
    always @(negedge clk) begin
        ar_fire = 1'b0;
        r_fire  = 1'b0;
        if (!reset) begin
            if (hold_pending) begin
                expect_true(T_BUS, ar.arvalid && (ar.araddr == held_addr),
                            "araddr or arvalid changed while waiting for arready");
            end
            hold_pending = ar.arvalid && !arready;
            held_addr    = ar.araddr;
            if (ar.arvalid && arready) begin
                if (seen_addr) begin
                    check_val(T_BUS, "araddr step", last_addr + 32'd4, ar.araddr);
                end
                seen_addr = 1'b1;
                last_addr = ar.araddr;
                ar_fire   = 1'b1;
                fire_addr = ar.araddr;
            end
            r_fire = r.rvalid && rready;
            if (retire.valid) begin
                cur_inst = prog[exp_pc[7:2]];
                if (cur_inst[6:0] == RV_OP) begin
                    kind = T_REG;
                end else if (cur_inst[6:0] == RV_OP_IMM || cur_inst[6:0] == RV_LUI) begin
                    kind = T_IMM;
                end else begin
                    kind = T_ILL;
                end
                model_result(cur_inst, e_val, e_wr, e_ill);
                check_val(T_ORDER, "pc", exp_pc, retire.pc);
                check_val(kind, "rd", {27'd0, cur_inst[11:7]}, {27'd0, retire.rd});
                check_val(kind, "value", e_val, retire.value);
                check_val(kind, "write flag", {31'd0, e_wr}, {31'd0, retire.write});
                check_val(kind, "illegal flag", {31'd0, e_ill}, {31'd0, retire.illegal});
                if (e_wr && cur_inst[11:7] != 5'd0) begin
                    mregs[cur_inst[11:7]] = e_val;
                end
                exp_pc    = exp_pc + 32'd4;
                n_retired = n_retired + 1;
            end
        end
    end

    initial begin
        seed         = 32'he06275a0;
        reset        = 1'b1;
        arready      = 1'b0;
        r            = '0;
        test_name    = '{"reset", "bus_handshake", "reg_ops", "imm_ops", "illegal_ops",
                         "retire_order"};
        n_checks     = '{default: 0};
        n_errs       = '{default: 0};
        mregs        = '{default: 32'd0};
        exp_pc       = RESET_PC;
        n_retired    = 0;
        timed_out    = 1'b0;
        hold_pending = 1'b0;
        seen_addr    = 1'b0;
        fill_program();

        repeat (2) @(posedge clk);
        #2;
        check_val(T_RESET, "arvalid", 32'd0, {31'd0, ar.arvalid});
        check_val(T_RESET, "rready", 32'd0, {31'd0, rready});
        check_val(T_RESET, "retire valid", 32'd0, {31'd0, retire.valid});
        reset = 1'b0;

        cycles = 0;
        while (!ar.arvalid && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!ar.arvalid) begin
            timed_out = 1'b1;
            $display("Timeout: fetch never raised arvalid after reset");
        end else begin
            check_val(T_RESET, "first araddr", RESET_PC, ar.araddr);
        end
        $display("%-14s %0d checks, %0d errors", test_name[T_RESET], n_checks[T_RESET],
                 n_errs[T_RESET]);

        while (!timed_out && n_retired < NUM_RETIRES) begin
            last_count = n_retired;
            cycles     = 0;
            while (n_retired == last_count && cycles < TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (n_retired == last_count) begin
                timed_out = 1'b1;
                $display("Timeout: no retire for %0d cycles, run stopped after %0d of %0d",
                         TIMEOUT, n_retired, NUM_RETIRES);
            end
        end

        total_checks = n_checks[T_RESET];
        total_errs   = n_errs[T_RESET];
        for (int t = T_BUS; t <= T_ORDER; t++) begin
            $display("%-14s %0d checks, %0d errors", test_name[t], n_checks[t], n_errs[t]);
            total_checks += n_checks[t];
            total_errs   += n_errs[t];
        end
        $display("Total: %0d retires, %0d checks, %0d errors", n_retired, total_checks,
                 total_errs);
        if (!timed_out && total_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/core_pkg.sv
verilog/bus_pkg.sv
verilog/int_alu.sv
verilog/int_regfile.sv
verilog/inst_decode.sv
verilog/inst_fetch.sv
verilog/inst_queue.sv
verilog/exec_stage.sv
verilog/cpu_top.sv
verification/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module cpu_tb -o cpu_tb_sim \
    && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^Result: PASSED$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
